/* source/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  // datapath widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int op_w       = 7;
  localparam int mask_w     = xlen / 8;  // one strobe per byte lane

  // major opcodes, inst[6:0]
  localparam logic [op_w-1:0] op_imm    = 7'b001_0011;  // addi only
  localparam logic [op_w-1:0] op_lui    = 7'b011_0111;
  localparam logic [op_w-1:0] op_auipc  = 7'b001_0111;
  localparam logic [op_w-1:0] op_jal    = 7'b110_1111;
  localparam logic [op_w-1:0] op_jalr   = 7'b110_0111;
  localparam logic [op_w-1:0] op_load   = 7'b000_0011;
  localparam logic [op_w-1:0] op_store  = 7'b010_0011;
  localparam logic [op_w-1:0] op_system = 7'b111_0011;  // ebreak

  // funct3 access sizes, shared by loads and stores
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;  // loads only
  localparam logic [2:0] f3_hu = 3'b101;  // loads only

  // register write-back source
  typedef enum logic [1:0] {
    wb_sum  = 2'd0,  // adder result
    wb_pc4  = 2'd1,  // link address
    wb_load = 2'd2   // aligned load data
  } wb_sel_t;

  // next pc source
  typedef enum logic {
    npc_pc4 = 1'b0,
    npc_sum = 1'b1   // jump target from adder
  } npc_sel_t;

endpackage

`default_nettype wire

/* source/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  logic [rv_core_pkg::xlen-1:0] inst,
  output logic [rv_core_pkg::xlen-1:0] imm
);

  logic [rv_core_pkg::op_w-1:0] opcode;
  logic [rv_core_pkg::xlen-1:0] imm_i;
  logic [rv_core_pkg::xlen-1:0] imm_s;
  logic [rv_core_pkg::xlen-1:0] imm_u;
  logic [rv_core_pkg::xlen-1:0] imm_j;

  assign opcode = inst[6:0];

  // all formats keep the sign in inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};  // already in upper bits
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      rv_core_pkg::op_imm,
      rv_core_pkg::op_jalr,
      rv_core_pkg::op_load:   imm = imm_i;
      rv_core_pkg::op_store:  imm = imm_s;
      rv_core_pkg::op_lui,
      rv_core_pkg::op_auipc:  imm = imm_u;
      rv_core_pkg::op_jal:    imm = imm_j;
      default:                imm = '0;  // no-op opcodes
    endcase
  end

endmodule

`default_nettype wire

/* source/ctrl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode (
  input  logic [rv_core_pkg::op_w-1:0] opcode,
  output logic                         reg_we,
  output logic                         use_pc,
  output logic                         zero_base,
  output rv_core_pkg::wb_sel_t         wb_sel,
  output rv_core_pkg::npc_sel_t        npc_sel,
  output logic                         is_load,
  output logic                         is_store,
  output logic                         halt
);

  always_comb begin
    // defaults give a plain no-op that falls through to pc + 4
    reg_we    = 1'b0;
    use_pc    = 1'b0;
    zero_base = 1'b0;
    wb_sel    = rv_core_pkg::wb_sum;
    npc_sel   = rv_core_pkg::npc_pc4;
    is_load   = 1'b0;
    is_store  = 1'b0;
    halt      = 1'b0;

    case (opcode)
      rv_core_pkg::op_imm: begin
        reg_we = 1'b1;  // rs1 + imm
      end
      rv_core_pkg::op_lui: begin
        reg_we    = 1'b1;
        zero_base = 1'b1;  // 0 + imm_u
      end
      rv_core_pkg::op_auipc: begin
        reg_we = 1'b1;
        use_pc = 1'b1;
      end
      rv_core_pkg::op_jal: begin
        reg_we  = 1'b1;
        use_pc  = 1'b1;
        wb_sel  = rv_core_pkg::wb_pc4;
        npc_sel = rv_core_pkg::npc_sum;
      end
      rv_core_pkg::op_jalr: begin
        reg_we  = 1'b1;
        wb_sel  = rv_core_pkg::wb_pc4;
        npc_sel = rv_core_pkg::npc_sum;
      end
      rv_core_pkg::op_load: begin
        reg_we  = 1'b1;
        wb_sel  = rv_core_pkg::wb_load;
        is_load = 1'b1;
      end
      rv_core_pkg::op_store: begin
        is_store = 1'b1;  // address only, no write-back
      end
      rv_core_pkg::op_system: begin
        halt = 1'b1;  // ebreak
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                               clk,
  input  logic [rv_core_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_core_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_core_pkg::xlen-1:0]       rs1_data,
  output logic [rv_core_pkg::xlen-1:0]       rs2_data,
  input  logic [rv_core_pkg::reg_addr_w-1:0] rd_addr,
  input  logic [rv_core_pkg::xlen-1:0]       rd_data,
  input  logic                               we
);

  logic [rv_core_pkg::xlen-1:0] regs [2**rv_core_pkg::reg_addr_w];

  always_ff @(posedge clk) begin
    if (we && (rd_addr != '0)) begin  // x0 never written
      regs[rd_addr] <= rd_data;
    end
  end

  // combinational reads, x0 hardwired to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* source/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align (
  input  logic [2:0]                   funct3,
  input  logic [1:0]                   byte_off,
  input  logic [rv_core_pkg::xlen-1:0] rdata,
  output logic [rv_core_pkg::xlen-1:0] load_data
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // pick the addressed lane first, extension works on that
  always_comb begin
    case (byte_off)
      2'd0:    byte_sel = rdata[7:0];
      2'd1:    byte_sel = rdata[15:8];
      2'd2:    byte_sel = rdata[23:16];
      default: byte_sel = rdata[31:24];
    endcase
  end

  assign half_sel = byte_off[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    load_data = '0;  // misaligned or unknown size
    case (funct3)
      rv_core_pkg::f3_b:
        load_data = {{(rv_core_pkg::xlen-8){byte_sel[7]}}, byte_sel};
      rv_core_pkg::f3_bu:
        load_data = {{(rv_core_pkg::xlen-8){1'b0}}, byte_sel};
      rv_core_pkg::f3_h: begin
        if (!byte_off[0]) begin
          load_data = {{(rv_core_pkg::xlen-16){half_sel[15]}}, half_sel};
        end
      end
      rv_core_pkg::f3_hu: begin
        if (!byte_off[0]) begin
          load_data = {{(rv_core_pkg::xlen-16){1'b0}}, half_sel};
        end
      end
      rv_core_pkg::f3_w: begin
        if (byte_off == 2'd0) begin
          load_data = rdata;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* source/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  logic [2:0]                     funct3,
  input  logic [1:0]                     byte_off,
  input  logic [rv_core_pkg::xlen-1:0]   src,
  output logic [rv_core_pkg::xlen-1:0]   wdata,
  output logic [rv_core_pkg::mask_w-1:0] wmask,
  output logic                           misaligned
);

  always_comb begin
    wdata      = src;
    wmask      = '0;
    misaligned = 1'b0;
    case (funct3)
      rv_core_pkg::f3_b: begin
        wdata = {rv_core_pkg::mask_w{src[7:0]}};  // byte on every lane
        wmask = {{(rv_core_pkg::mask_w-1){1'b0}}, 1'b1} << byte_off;
      end
      rv_core_pkg::f3_h: begin
        wdata = {(rv_core_pkg::mask_w/2){src[15:0]}};
        if (byte_off[0]) begin
          misaligned = 1'b1;
        end else begin
          wmask = byte_off[1] ? 4'b1100 : 4'b0011;
        end
      end
      rv_core_pkg::f3_w: begin
        if (byte_off != 2'd0) begin
          misaligned = 1'b1;
        end else begin
          wmask = '1;
        end
      end
      default: misaligned = 1'b1;  // bad size, treated as a rejected access
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter logic [rv_core_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [rv_core_pkg::xlen-1:0]   inst,
  output logic [rv_core_pkg::xlen-1:0]   pc,
  output logic [rv_core_pkg::xlen-1:0]   dmem_addr,
  output logic [rv_core_pkg::xlen-1:0]   dmem_wdata,
  output logic [rv_core_pkg::mask_w-1:0] dmem_wmask,
  output logic                           dmem_we,
  output logic                           dmem_re,
  input  logic [rv_core_pkg::xlen-1:0]   dmem_rdata,
  output logic                           halt
);

  logic                               reg_we;
  logic                               use_pc;
  logic                               zero_base;
  logic                               is_load;
  logic                               is_store;
  logic                               dec_halt;
  rv_core_pkg::wb_sel_t               wb_sel;
  rv_core_pkg::npc_sel_t              npc_sel;
  logic                               rf_we;
  logic [rv_core_pkg::xlen-1:0]       imm;
  logic [rv_core_pkg::xlen-1:0]       rs1_data;
  logic [rv_core_pkg::xlen-1:0]       rs2_data;
  logic [rv_core_pkg::xlen-1:0]       op_a;
  logic [rv_core_pkg::xlen-1:0]       sum;
  logic [rv_core_pkg::xlen-1:0]       pc_plus4;
  logic [rv_core_pkg::xlen-1:0]       next_pc;
  logic [rv_core_pkg::xlen-1:0]       rd_data;
  logic [rv_core_pkg::xlen-1:0]       load_data;
  logic [rv_core_pkg::mask_w-1:0]     st_wmask;
  logic                               st_misaligned;

  ctrl_decode i_ctrl_decode (
    .opcode    (inst[6:0]),
    .reg_we    (reg_we),
    .use_pc    (use_pc),
    .zero_base (zero_base),
    .wb_sel    (wb_sel),
    .npc_sel   (npc_sel),
    .is_load   (is_load),
    .is_store  (is_store),
    .halt      (dec_halt)
  );

  imm_gen i_imm_gen (
    .inst (inst),
    .imm  (imm)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rs1_addr (inst[19:15]),
    .rs2_addr (inst[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_addr  (inst[11:7]),
    .rd_data  (rd_data),
    .we       (rf_we)
  );

  // single adder for addresses, targets and addi/lui/auipc results
  assign op_a     = zero_base ? '0 : (use_pc ? pc : rs1_data);
  assign sum      = op_a + imm;
  assign pc_plus4 = pc + 32'd4;

  load_align i_load_align (
    .funct3    (inst[14:12]),
    .byte_off  (sum[1:0]),
    .rdata     (dmem_rdata),
    .load_data (load_data)
  );

  store_align i_store_align (
    .funct3     (inst[14:12]),
    .byte_off   (sum[1:0]),
    .src        (rs2_data),
    .wdata      (dmem_wdata),
    .wmask      (st_wmask),
    .misaligned (st_misaligned)
  );

  always_comb begin
    case (wb_sel)
      rv_core_pkg::wb_pc4:  rd_data = pc_plus4;  // link
      rv_core_pkg::wb_load: rd_data = load_data;
      default:              rd_data = sum;
    endcase
  end

  // jalr target drops bit 0, jal target is even anyway
  assign next_pc = (npc_sel == rv_core_pkg::npc_sum) ? {sum[rv_core_pkg::xlen-1:1], 1'b0}
                                                     : pc_plus4;

  assign halt  = dec_halt & ~reset;
  assign rf_we = reg_we & ~reset;  // ebreak already has reg_we low

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (!halt) begin
      pc <= next_pc;  // held while halted
    end
  end

  // data memory side
  assign dmem_addr  = sum;
  assign dmem_re    = is_load;
  assign dmem_we    = is_store & ~st_misaligned & ~reset;
  assign dmem_wmask = dmem_we ? st_wmask : '0;  // strobes only with a write

endmodule

`default_nettype wire

/* bench/rv_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_props #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input logic        clk,
  input logic        reset,
  input logic [31:0] pc,
  input logic [3:0]  dmem_wmask,
  input logic        dmem_we,
  input logic        dmem_re,
  input logic        halt
);

  a_we_re: assert property (@(posedge clk) !(dmem_we && dmem_re))
    else $error("dmem_we and dmem_re high in the same cycle");

  // strobes only with a write
  a_mask: assert property (@(posedge clk) (dmem_wmask != 4'h0) == dmem_we)
    else $error("dmem_wmask does not follow dmem_we");

  a_halt: assert property (@(posedge clk) disable iff (reset) halt |=> $stable(pc))
    else $error("pc moved while halted");

  a_reset: assert property (@(posedge clk) reset |=> (pc == reset_pc))
    else $error("pc differs from reset_pc after reset");

endmodule

bind rv_core_top rv_core_props #(.reset_pc(reset_pc)) i_props (
  .clk(clk), .reset(reset), .pc(pc), .dmem_wmask(dmem_wmask),
  .dmem_we(dmem_we), .dmem_re(dmem_re), .halt(halt)
);

`default_nettype wire

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam logic [31:0] reset_pc       = 32'h8000_0000;
  localparam logic [31:0] data_base      = 32'h0001_0000;  // 1 KB data region
  localparam logic [31:0] ebreak_word    = 32'h0010_0073;
  localparam logic [31:0] sw_zero_word   = 32'h0000_2023;  // sw x0, 0(x0)
  localparam logic [31:0] seed           = 32'h65da_e27e;
  localparam int          prog_len       = 200;
  localparam int          timeout_cycles = prog_len * 2 + 50;

  logic        clk   = 1'b0;
  logic        reset = 1'b1;
  logic [31:0] reset_inst = sw_zero_word;  // word at inst while reset is high
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wmask;
  logic        dmem_we;
  logic        dmem_re;
  logic [31:0] dmem_rdata;
  logic        halt;

  logic [31:0] imem [prog_len];
  logic [31:0] dmem [256];
  logic [31:0] m_regs [32];  // model state
  logic [31:0] m_mem [256];
  logic [31:0] m_pc;
  logic        m_halted;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  rv_core_top #(.reset_pc(reset_pc)) i_dut (
    .clk(clk), .reset(reset), .inst(inst), .pc(pc), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask), .dmem_we(dmem_we),
    .dmem_re(dmem_re), .dmem_rdata(dmem_rdata), .halt(halt)
  );

  always #10 clk = ~clk;

  // anything outside the program reads as ebreak
  function automatic logic [31:0] fetch(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - reset_pc) >> 2;
    return (idx < prog_len) ? imem[idx[7:0]] : ebreak_word;
  endfunction

  assign inst       = reset ? reset_inst : fetch(pc);
  assign dmem_rdata = (dmem_addr[31:10] == data_base[31:10]) ? dmem[dmem_addr[9:2]] : '0;

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmem_we && dmem_wmask[b]) begin
        dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: core did not reach ebreak within %0d cycles", timeout_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int start);
    $display("test %s done, %0d errors", name, errors - start);
  endtask

  // x1 is the data base and x2 the jump base, neither is overwritten
  function automatic logic [4:0] pick_rd();
    logic [4:0] r;
    r = 5'($urandom_range(31, 2));
    return (r == 5'd2) ? 5'd0 : r;
  endfunction

  function automatic logic [11:0] aligned_off(input logic [2:0] f3);
    logic [11:0] off;
    off = 12'($urandom_range(1023, 0));
    if (f3[1:0] == 2'd1) off[0] = 1'b0;
    if (f3[1:0] == 2'd2) off[1:0] = 2'b00;
    return off;
  endfunction

  function automatic logic [31:0] byte_bits(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  function automatic logic [3:0] store_mask(input logic [2:0] f3, input logic [1:0] off);
    if (f3 == 3'd0) return 4'b0001 << off;
    if (f3 == 3'd1) return 4'b0011 << off;
    return 4'b1111;
  endfunction

  function automatic logic [31:0] load_value(input logic [31:0] word, input logic [2:0] f3,
                                             input logic [1:0] off);
    logic [31:0] sh;
    sh = word >> {off, 3'b000};
    case (f3)
      3'd0:    return {{24{sh[7]}}, sh[7:0]};
      3'd1:    return {{16{sh[15]}}, sh[15:0]};
      3'd4:    return {24'h0, sh[7:0]};
      3'd5:    return {16'h0, sh[15:0]};
      default: return word;
    endcase
  endfunction

  task automatic build_program();
    int          tgt;
    logic [2:0]  f3;
    logic [11:0] off;
    logic [20:0] jo;
    imem[0] = {data_base[31:12], 5'd1, rv_core_pkg::op_lui};
    imem[1] = {reset_pc[31:12], 5'd2, rv_core_pkg::op_lui};
    for (int i = 2; i < 31; i++) begin
      imem[i] = {12'($urandom), 5'd0, 3'b000, 5'(i + 1), rv_core_pkg::op_imm};
    end
    for (int i = 31; i < prog_len - 1; i++) begin
      tgt = i + int'($urandom_range(8, 1));  // forward jump target
      if (tgt > prog_len - 1) tgt = prog_len - 1;
      case ($urandom_range(9, 0))
        0, 1: imem[i] = {12'($urandom), 5'($urandom), 3'b000, pick_rd(), rv_core_pkg::op_imm};
        2: imem[i] = {20'($urandom), pick_rd(), rv_core_pkg::op_lui};
        3: imem[i] = {20'($urandom), pick_rd(), rv_core_pkg::op_auipc};
        4: begin
          jo = 21'((tgt - i) * 4);
          imem[i] = {jo[20], jo[10:1], jo[11], jo[19:12], pick_rd(), rv_core_pkg::op_jal};
        end
        5: imem[i] = {12'(tgt * 4), 5'd2, 3'b000, pick_rd(), rv_core_pkg::op_jalr};
        6, 7: begin
          f3 = 3'($urandom_range(5, 0));
          if (f3 == 3'd3) f3 = rv_core_pkg::f3_w;
          imem[i] = {aligned_off(f3), 5'd1, f3, pick_rd(), rv_core_pkg::op_load};
        end
        default: begin
          f3  = 3'($urandom_range(2, 0));  // sb, sh, sw
          off = aligned_off(f3);
          imem[i] = {off[11:5], 5'($urandom), 5'd1, f3, off[4:0], rv_core_pkg::op_store};
        end
      endcase
    end
    imem[prog_len-1] = ebreak_word;
  endtask

  // one instruction of the model, checked against the DUT outputs of this cycle
  task automatic step_model();
    logic [31:0] w;
    logic [31:0] rs1v;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] lane;
    logic [31:0] npc;
    logic [3:0]  mask;
    logic        wr;
    w    = fetch(m_pc);
    rs1v = m_regs[w[19:15]];
    addr = rs1v + {{20{w[31]}}, w[31:20]};
    res  = '0;
    mask = '0;
    wr   = 1'b1;
    npc  = m_pc + 32'd4;
    check("pc", pc, m_pc);
    case (w[6:0])
      rv_core_pkg::op_imm:   res = addr;
      rv_core_pkg::op_lui:   res = {w[31:12], 12'h000};
      rv_core_pkg::op_auipc: res = m_pc + {w[31:12], 12'h000};
      rv_core_pkg::op_jal: begin
        res = m_pc + 32'd4;  // link
        npc = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      rv_core_pkg::op_jalr: begin
        res = m_pc + 32'd4;
        npc = addr & ~32'd1;
      end
      rv_core_pkg::op_load: res = load_value(m_mem[addr[9:2]], w[14:12], addr[1:0]);
      rv_core_pkg::op_store: begin
        wr   = 1'b0;
        addr = rs1v + {{20{w[31]}}, w[31:25], w[11:7]};
        mask = store_mask(w[14:12], addr[1:0]);
        lane = m_regs[w[24:20]] << {addr[1:0], 3'b000};
        check("dmem_addr", dmem_addr, addr);
        check("dmem_wdata", dmem_wdata & byte_bits(mask), lane & byte_bits(mask));
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) m_mem[addr[9:2]][8*b +: 8] = lane[8*b +: 8];
        end
      end
      rv_core_pkg::op_system: begin
        wr       = 1'b0;
        npc      = m_pc;  // stays on ebreak
        m_halted = 1'b1;
      end
      default: wr = 1'b0;
    endcase
    check("dmem_we", 32'(dmem_we), 32'(mask != 4'h0));
    check("dmem_wmask", 32'(dmem_wmask), 32'(mask));
    check("dmem_re", 32'(dmem_re), 32'(w[6:0] == rv_core_pkg::op_load));
    check("halt", 32'(halt), 32'(m_halted));
    if (wr && w[11:7] != 5'd0) m_regs[w[11:7]] = res;
    m_pc = npc;
  endtask

  initial begin
    int start;
    void'($urandom(seed));
    build_program();
    for (int k = 0; k < 256; k++) begin
      dmem[k]  = $urandom;
      m_mem[k] = dmem[k];
    end
    for (int k = 0; k < 32; k++) begin
      m_regs[k] = '0;
    end
    m_pc     = reset_pc;
    m_halted = 1'b0;

    start = errors;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check("dmem_we", 32'(dmem_we), 32'd0);  // aligned store at inst
    check("dmem_wmask", 32'(dmem_wmask), 32'd0);
    @(posedge clk);
    #1 reset_inst = ebreak_word;
    @(negedge clk);
    check("pc", pc, reset_pc);
    check("halt", 32'(halt), 32'd0);
    @(posedge clk);
    #1 reset = 1'b0;
    report_test("reset", start);

    start = errors;
    while (!m_halted) begin
      @(negedge clk);
      step_model();
    end
    report_test("program", start);

    start = errors;
    repeat (3) begin  // pc must hold on ebreak
      @(negedge clk);
      step_model();
    end
    report_test("halt", start);

    start = errors;
    for (int k = 0; k < 256; k++) begin
      check($sformatf("dmem[%0d]", k), dmem[k], m_mem[k]);
    end
    report_test("memory", start);

    $display("tests 4, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
source/rv_core_pkg.sv
source/imm_gen.sv
source/ctrl_decode.sv
source/reg_file.sv
source/load_align.sv
source/store_align.sv
source/rv_core_top.sv
bench/rv_core_props.sv
bench/rv_core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation log has no result line"
  exit 1
fi
exit 0
